/* include/lcCtrl_config.svh */
// ----------------------------------------------------------
// Build-time constants of the life cycle controller
// Register offsets are byte addresses on a 5-bit bus
// The reset contents model a blank store and are not real OTP
// ----------------------------------------------------------
`ifndef LCCTRL_CONFIG_SVH
`define LCCTRL_CONFIG_SVH

// Highest transition count the store can hold
`define LC_CNT_MAX 5'd24

// Number of copies of each decoded state index
`define LC_DEC_NUM_REP 2

// Word offsets of the register map
`define LC_ADDR_STATUS 5'h00
`define LC_ADDR_CMD    5'h04
`define LC_ADDR_TARGET 5'h08
`define LC_ADDR_STATE  5'h0C
`define LC_ADDR_CNT    5'h10

// Contents of the store after reset
`define LC_RESET_STATE lcCtrlPkg::LcStRaw
`define LC_RESET_CNT   lcCtrlPkg::LcCnt0

`endif

/* logic/lcCtrlPkg.sv */
// ----------------------------------------------------------
// Types shared by the life cycle controller blocks
// Only 13 states exist, so the transition rule is a function
// and not a token matrix
// ----------------------------------------------------------
`include "lcCtrl_config.svh"

package lcCtrlPkg;

  // Sparse persistent state word, every other value is invalid
  typedef enum logic [15:0] {
    LcStRaw           = 16'h0000,
    LcStTestUnlocked0 = 16'h5A3C,
    LcStTestUnlocked1 = 16'h96E1,
    LcStTestUnlocked2 = 16'hC38F,
    LcStTestUnlocked3 = 16'h2DB7,
    LcStTestLocked0   = 16'hE41B,
    LcStTestLocked1   = 16'h7C62,
    LcStTestLocked2   = 16'hB1D4,
    LcStDev           = 16'h4F8A,
    LcStProd          = 16'h8B3E,
    LcStProdEnd       = 16'h1EC9,
    LcStRma           = 16'hD76D,
    LcStScrap         = 16'hFFFF
  } lcState_e;

  // Transition counter, LcCnt0 up to LcCnt24
  typedef enum logic [4:0] {LcCnt[0:24]} lcCnt_e;

  // Dense index of a state; the TestUnlocked and TestLocked runs are contiguous
  typedef enum logic [3:0] {
    DecLcStRaw, DecLcStTestUnlocked0, DecLcStTestUnlocked1, DecLcStTestUnlocked2,
    DecLcStTestUnlocked3, DecLcStTestLocked0, DecLcStTestLocked1, DecLcStTestLocked2,
    DecLcStDev, DecLcStProd, DecLcStProdEnd, DecLcStRma, DecLcStScrap,
    DecLcStInvalid = 4'd15
  } decLcState_e;

  // Replicated index so that a single flipped bit cannot pass as a state
  typedef decLcState_e [`LC_DEC_NUM_REP-1:0] extDecLcState_t;

  typedef enum logic [2:0] {
    ResetSt, IdleSt, CntIncrSt, CntProgSt, TransCheckSt, TransProgSt, PostTransSt
  } fsmState_e;

  // Returns 1 when the edge from cur to tgt is allowed
  function automatic logic transValid(input decLcState_e cur, input decLcState_e tgt);
    logic ok;
    ok = 1'b0;
    if (tgt == DecLcStScrap) begin
      // Scrap is reachable from anywhere but itself
      ok = (cur != DecLcStScrap);
    end else begin
      case (cur)
        DecLcStRaw: ok = (tgt == DecLcStTestUnlocked0);
        DecLcStTestUnlocked0, DecLcStTestUnlocked1, DecLcStTestUnlocked2,
        DecLcStTestUnlocked3: begin
          // TestUnlockedN sits 4 indexes below TestLockedN
          ok = (tgt inside {DecLcStDev, DecLcStProd, DecLcStProdEnd, DecLcStRma}) ||
               (cur != DecLcStTestUnlocked3 && 5'(tgt) == 5'(cur) + 5'd4);
        end
        DecLcStTestLocked0, DecLcStTestLocked1, DecLcStTestLocked2: begin
          // Only a higher unlocked level may follow a locked one
          ok = (tgt inside {[DecLcStTestUnlocked0:DecLcStTestUnlocked3]}) &&
               (5'(tgt) + 5'd4 > 5'(cur));
        end
        DecLcStDev:  ok = (tgt inside {DecLcStProd, DecLcStProdEnd, DecLcStRma});
        DecLcStProd: ok = (tgt inside {DecLcStProdEnd, DecLcStRma});
        default:     ok = 1'b0;
      endcase
    end
    return ok;
  endfunction

endpackage

/* logic/lcCtrlRegs.sv */
// ----------------------------------------------------------
// Wishbone classic register block with one wait state
// Select lines are absent, every access is a full word
// ----------------------------------------------------------
`include "lcCtrl_config.svh"

module lcCtrlRegs (
  input  logic                      clk_i,
  input  logic                      arstN_i,
  // Wishbone slave side
  input  logic                      wbCyc_i,
  input  logic                      wbStb_i,
  input  logic                      wbWe_i,
  input  logic [4:0]                wbAdr_i,
  input  logic [31:0]               wbDat_i,
  output logic [31:0]               wbDat_o,
  output logic                      wbAck_o,
  // Status from the FSM
  input  logic                      busy_i,
  input  logic                      done_i,
  input  logic                      cntOflwErr_i,
  input  logic                      transInvalidErr_i,
  // Current contents of the store
  input  lcCtrlPkg::decLcState_e    decLcState_i,
  input  lcCtrlPkg::lcCnt_e         lcCnt_i,
  // Request towards the FSM and the transition function
  output logic                      transCmd_o,
  output lcCtrlPkg::extDecLcState_t transTarget_o
);

  logic                   ackQ;
  logic                   transCmdQ;
  logic                   reqAccept;
  lcCtrlPkg::decLcState_e targetQ;
  logic [31:0]            rdData;

  // A request is taken in the cycle before the acknowledge
  assign reqAccept = wbCyc_i && wbStb_i && !ackQ;

  // ----------------------------------------------------------
  // Acknowledge, command pulse and target register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      ackQ      <= 1'b0;
      transCmdQ <= 1'b0;
      targetQ   <= lcCtrlPkg::DecLcStRaw;
    end else begin
      ackQ <= reqAccept;
      // The pulse lines up with the acknowledge of the CMD write
      transCmdQ <= reqAccept && wbWe_i && (wbAdr_i == `LC_ADDR_CMD) && wbDat_i[0];
      if (reqAccept && wbWe_i && wbAdr_i == `LC_ADDR_TARGET) begin
        targetQ <= lcCtrlPkg::decLcState_e'(wbDat_i[3:0]);
      end
    end
  end

  // ----------------------------------------------------------
  // Read data path
  // ----------------------------------------------------------
  always_comb begin
    rdData = 32'h0;
    case (wbAdr_i)
      `LC_ADDR_STATUS: rdData = {28'h0, transInvalidErr_i, cntOflwErr_i, done_i, busy_i};
      `LC_ADDR_TARGET: rdData = {28'h0, targetQ};
      `LC_ADDR_STATE:  rdData = {28'h0, decLcState_i};
      `LC_ADDR_CNT:    rdData = {27'h0, lcCnt_i};
      // CMD and unmapped offsets read as zero
      default:         rdData = 32'h0;
    endcase
  end

  // Read data is captured with the request and held with the acknowledge
  always_ff @(posedge clk_i) begin
    if (reqAccept) begin
      wbDat_o <= rdData;
    end
  end

  assign wbAck_o       = ackQ;
  assign transCmd_o    = transCmdQ;
  assign transTarget_o = lcCtrlPkg::extDecLcState_t'({`LC_DEC_NUM_REP{targetQ}});

endmodule

/* logic/lcCtrlFsm.sv */
// ----------------------------------------------------------
// Main life cycle FSM, one request at a time
// Commands that arrive outside IdleSt are dropped
// ----------------------------------------------------------
module lcCtrlFsm (
  input  logic                 clk_i,
  input  logic                 arstN_i,
  input  logic                 transCmd_i,
  // Error flags straight from the transition function
  input  logic                 cntOflwErr_i,
  input  logic                 transInvalidErr_i,
  output lcCtrlPkg::fsmState_e fsmState_o,
  // Store write strobes
  output logic                 progCnt_o,
  output logic                 progState_o,
  // Status towards the registers
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 cntOflwErr_o,
  output logic                 transInvalidErr_o
);

  lcCtrlPkg::fsmState_e stateD, stateQ;
  logic                 doneQ;
  logic                 cntOflwErrQ;
  logic                 transInvalidErrQ;
  logic                 cmdAccept;

  // Only a command seen in IdleSt starts a sequence
  assign cmdAccept = transCmd_i && (stateQ == lcCtrlPkg::IdleSt);

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    stateD = stateQ;
    case (stateQ)
      lcCtrlPkg::ResetSt: stateD = lcCtrlPkg::IdleSt;
      lcCtrlPkg::IdleSt: begin
        if (transCmd_i) begin
          stateD = lcCtrlPkg::CntIncrSt;
        end
      end
      // The counter is bumped first so that every attempt costs one count
      lcCtrlPkg::CntIncrSt: begin
        stateD = cntOflwErr_i ? lcCtrlPkg::PostTransSt : lcCtrlPkg::CntProgSt;
      end
      lcCtrlPkg::CntProgSt: stateD = lcCtrlPkg::TransCheckSt;
      // An illegal edge stops here with the counter already written
      lcCtrlPkg::TransCheckSt: begin
        stateD = transInvalidErr_i ? lcCtrlPkg::PostTransSt : lcCtrlPkg::TransProgSt;
      end
      lcCtrlPkg::TransProgSt: stateD = lcCtrlPkg::PostTransSt;
      lcCtrlPkg::PostTransSt: stateD = lcCtrlPkg::IdleSt;
      // Unused encodings fall back to idle
      default: stateD = lcCtrlPkg::IdleSt;
    endcase
  end

  // ----------------------------------------------------------
  // State and sticky status flags
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      stateQ           <= lcCtrlPkg::IdleSt;
      doneQ            <= 1'b0;
      cntOflwErrQ      <= 1'b0;
      transInvalidErrQ <= 1'b0;
    end else begin
      stateQ <= stateD;
      if (cmdAccept) begin
        // A new request wipes the result of the previous one
        doneQ            <= 1'b0;
        cntOflwErrQ      <= 1'b0;
        transInvalidErrQ <= 1'b0;
      end else begin
        // Done rises together with the move into PostTransSt
        if (stateD == lcCtrlPkg::PostTransSt) begin
          doneQ <= 1'b1;
        end
        if (stateQ == lcCtrlPkg::CntIncrSt && cntOflwErr_i) begin
          cntOflwErrQ <= 1'b1;
        end
        if (stateQ == lcCtrlPkg::TransCheckSt && transInvalidErr_i) begin
          transInvalidErrQ <= 1'b1;
        end
      end
    end
  end

  // Strobes last exactly one cycle since each state is left after one cycle
  assign progCnt_o   = (stateQ == lcCtrlPkg::CntProgSt);
  assign progState_o = (stateQ == lcCtrlPkg::TransProgSt);

  assign busy_o = stateQ inside {lcCtrlPkg::CntIncrSt, lcCtrlPkg::CntProgSt,
                                 lcCtrlPkg::TransCheckSt, lcCtrlPkg::TransProgSt};

  assign fsmState_o        = stateQ;
  assign done_o            = doneQ;
  assign cntOflwErr_o      = cntOflwErrQ;
  assign transInvalidErr_o = transInvalidErrQ;

endmodule

/* logic/lcCtrlStateTransition.sv */
// ----------------------------------------------------------
// Transition function, purely combinational
// Errors are only meaningful in the FSM states that sample them
// ----------------------------------------------------------
`include "lcCtrl_config.svh"

module lcCtrlStateTransition (
  // Present contents of the store
  input  lcCtrlPkg::lcState_e       lcState_i,
  input  lcCtrlPkg::lcCnt_e         lcCnt_i,
  input  lcCtrlPkg::fsmState_e      fsmState_i,
  // Replicated indexes of the current and the requested state
  input  lcCtrlPkg::extDecLcState_t decLcState_i,
  input  lcCtrlPkg::extDecLcState_t transTarget_i,
  // Values to program
  output lcCtrlPkg::lcState_e       nextLcState_o,
  output lcCtrlPkg::lcCnt_e         nextLcCnt_o,
  output logic                      transCntOflwError_o,
  output logic                      transInvalidError_o
);

  always_comb begin
    nextLcState_o       = lcState_i;
    nextLcCnt_o         = lcCnt_i;
    transCntOflwError_o = 1'b0;
    transInvalidError_o = 1'b0;

    // ----------------------------------------------------------
    // Counter phase
    // ----------------------------------------------------------
    // Keep the incremented count up to TransProgSt so the value stays stable
    if (fsmState_i inside {lcCtrlPkg::CntIncrSt, lcCtrlPkg::CntProgSt,
                           lcCtrlPkg::TransCheckSt, lcCtrlPkg::TransProgSt}) begin
      if (lcCnt_i >= `LC_CNT_MAX) begin
        transCntOflwError_o = 1'b1;
      end else begin
        nextLcCnt_o = lcCtrlPkg::lcCnt_e'(lcCnt_i + 5'd1);
      end
      // Scrap is always reachable, so the counter is pinned at its maximum
      // and the state is forced early to keep the silenced error from being abused
      if (transTarget_i == {`LC_DEC_NUM_REP{lcCtrlPkg::DecLcStScrap}}) begin
        nextLcCnt_o         = lcCtrlPkg::lcCnt_e'(`LC_CNT_MAX);
        nextLcState_o       = lcCtrlPkg::LcStScrap;
        transCntOflwError_o = 1'b0;
      end
    end

    // ----------------------------------------------------------
    // Edge check and target encoding
    // ----------------------------------------------------------
    if (fsmState_i inside {lcCtrlPkg::TransCheckSt, lcCtrlPkg::TransProgSt}) begin
      // Each copy is range checked and run through the rule on its own
      for (int k = 0; k < `LC_DEC_NUM_REP; k++) begin
        if (decLcState_i[k] > lcCtrlPkg::DecLcStScrap ||
            transTarget_i[k] > lcCtrlPkg::DecLcStScrap ||
            !lcCtrlPkg::transValid(decLcState_i[k], transTarget_i[k])) begin
          transInvalidError_o = 1'b1;
        end
      end

      // Copies that disagree mean the replicated word is corrupted
      if (transTarget_i != {`LC_DEC_NUM_REP{transTarget_i[0]}}) begin
        transInvalidError_o = 1'b1;
      end else if (!transInvalidError_o) begin
        case (transTarget_i[0])
          lcCtrlPkg::DecLcStRaw:           nextLcState_o = lcCtrlPkg::LcStRaw;
          lcCtrlPkg::DecLcStTestUnlocked0: nextLcState_o = lcCtrlPkg::LcStTestUnlocked0;
          lcCtrlPkg::DecLcStTestUnlocked1: nextLcState_o = lcCtrlPkg::LcStTestUnlocked1;
          lcCtrlPkg::DecLcStTestUnlocked2: nextLcState_o = lcCtrlPkg::LcStTestUnlocked2;
          lcCtrlPkg::DecLcStTestUnlocked3: nextLcState_o = lcCtrlPkg::LcStTestUnlocked3;
          lcCtrlPkg::DecLcStTestLocked0:   nextLcState_o = lcCtrlPkg::LcStTestLocked0;
          lcCtrlPkg::DecLcStTestLocked1:   nextLcState_o = lcCtrlPkg::LcStTestLocked1;
          lcCtrlPkg::DecLcStTestLocked2:   nextLcState_o = lcCtrlPkg::LcStTestLocked2;
          lcCtrlPkg::DecLcStDev:           nextLcState_o = lcCtrlPkg::LcStDev;
          lcCtrlPkg::DecLcStProd:          nextLcState_o = lcCtrlPkg::LcStProd;
          lcCtrlPkg::DecLcStProdEnd:       nextLcState_o = lcCtrlPkg::LcStProdEnd;
          lcCtrlPkg::DecLcStRma:           nextLcState_o = lcCtrlPkg::LcStRma;
          lcCtrlPkg::DecLcStScrap:         nextLcState_o = lcCtrlPkg::LcStScrap;
          default:                         transInvalidError_o = 1'b1;
        endcase
      end

      // The current state must decode to the same valid index in every copy
      if (decLcState_i != {`LC_DEC_NUM_REP{decLcState_i[0]}} ||
          decLcState_i[0] > lcCtrlPkg::DecLcStScrap) begin
        transInvalidError_o = 1'b1;
      end
    end
  end

endmodule

/* logic/lcCtrlStateStore.sv */
// ----------------------------------------------------------
// Simulation model of the persistent state and counter
// Contents restart at Raw and count 0 on every reset
// ----------------------------------------------------------
`include "lcCtrl_config.svh"

module lcCtrlStateStore (
  input  logic                      clk_i,
  input  logic                      arstN_i,
  // One-cycle write strobes from the FSM
  input  logic                      progCnt_i,
  input  logic                      progState_i,
  input  lcCtrlPkg::lcState_e       nextLcState_i,
  input  lcCtrlPkg::lcCnt_e         nextLcCnt_i,
  output lcCtrlPkg::lcState_e       lcState_o,
  output lcCtrlPkg::lcCnt_e         lcCnt_o,
  output lcCtrlPkg::extDecLcState_t decLcState_o
);

  lcCtrlPkg::lcState_e    lcStateQ;
  lcCtrlPkg::lcCnt_e      lcCntQ;
  lcCtrlPkg::decLcState_e decIdx;

  // Counter and state are written independently, as two OTP passes would be
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      lcStateQ <= `LC_RESET_STATE;
      lcCntQ   <= `LC_RESET_CNT;
    end else begin
      if (progCnt_i) begin
        lcCntQ <= nextLcCnt_i;
      end
      if (progState_i) begin
        lcStateQ <= nextLcState_i;
      end
    end
  end

  // Sparse word to dense index, any unknown word decodes as invalid
  always_comb begin
    case (lcStateQ)
      lcCtrlPkg::LcStRaw:           decIdx = lcCtrlPkg::DecLcStRaw;
      lcCtrlPkg::LcStTestUnlocked0: decIdx = lcCtrlPkg::DecLcStTestUnlocked0;
      lcCtrlPkg::LcStTestUnlocked1: decIdx = lcCtrlPkg::DecLcStTestUnlocked1;
      lcCtrlPkg::LcStTestUnlocked2: decIdx = lcCtrlPkg::DecLcStTestUnlocked2;
      lcCtrlPkg::LcStTestUnlocked3: decIdx = lcCtrlPkg::DecLcStTestUnlocked3;
      lcCtrlPkg::LcStTestLocked0:   decIdx = lcCtrlPkg::DecLcStTestLocked0;
      lcCtrlPkg::LcStTestLocked1:   decIdx = lcCtrlPkg::DecLcStTestLocked1;
      lcCtrlPkg::LcStTestLocked2:   decIdx = lcCtrlPkg::DecLcStTestLocked2;
      lcCtrlPkg::LcStDev:           decIdx = lcCtrlPkg::DecLcStDev;
      lcCtrlPkg::LcStProd:          decIdx = lcCtrlPkg::DecLcStProd;
      lcCtrlPkg::LcStProdEnd:       decIdx = lcCtrlPkg::DecLcStProdEnd;
      lcCtrlPkg::LcStRma:           decIdx = lcCtrlPkg::DecLcStRma;
      lcCtrlPkg::LcStScrap:         decIdx = lcCtrlPkg::DecLcStScrap;
      default:                      decIdx = lcCtrlPkg::DecLcStInvalid;
    endcase
  end

  assign lcState_o    = lcStateQ;
  assign lcCnt_o      = lcCntQ;
  assign decLcState_o = lcCtrlPkg::extDecLcState_t'({`LC_DEC_NUM_REP{decIdx}});

endmodule

/* logic/lcCtrlTop.sv */
// ----------------------------------------------------------
// Life cycle controller top, Wishbone classic slave
// No token check, escalation or real OTP port
// ----------------------------------------------------------
module lcCtrlTop (
  input  logic        clk_i,
  input  logic        arstN_i,
  input  logic        wbCyc_i,
  input  logic        wbStb_i,
  input  logic        wbWe_i,
  input  logic [4:0]  wbAdr_i,
  input  logic [31:0] wbDat_i,
  output logic [31:0] wbDat_o,
  output logic        wbAck_o
);

  logic                      transCmd;
  lcCtrlPkg::extDecLcState_t transTarget;
  lcCtrlPkg::fsmState_e      fsmState;
  logic                      progCnt, progState;
  lcCtrlPkg::lcState_e       nextLcState, lcState;
  lcCtrlPkg::lcCnt_e         nextLcCnt, lcCnt;
  lcCtrlPkg::extDecLcState_t decLcState;
  // Raw flags from the transition function and their sticky copies
  logic                      transCntOflwErr, transInvalidErr;
  logic                      busy, done, cntOflwErrSticky, transInvalidErrSticky;

  lcCtrlRegs u_regs (
    .clk_i, .arstN_i,
    .wbCyc_i, .wbStb_i, .wbWe_i, .wbAdr_i, .wbDat_i, .wbDat_o, .wbAck_o,
    .busy_i(busy), .done_i(done),
    .cntOflwErr_i(cntOflwErrSticky), .transInvalidErr_i(transInvalidErrSticky),
    // Copies agree when the store is intact, the first one is reported
    .decLcState_i(decLcState[0]), .lcCnt_i(lcCnt),
    .transCmd_o(transCmd), .transTarget_o(transTarget)
  );

  lcCtrlFsm u_fsm (
    .clk_i, .arstN_i,
    .transCmd_i(transCmd),
    .cntOflwErr_i(transCntOflwErr), .transInvalidErr_i(transInvalidErr),
    .fsmState_o(fsmState), .progCnt_o(progCnt), .progState_o(progState),
    .busy_o(busy), .done_o(done),
    .cntOflwErr_o(cntOflwErrSticky), .transInvalidErr_o(transInvalidErrSticky)
  );

  lcCtrlStateTransition u_trans (
    .lcState_i(lcState), .lcCnt_i(lcCnt), .fsmState_i(fsmState),
    .decLcState_i(decLcState), .transTarget_i(transTarget),
    .nextLcState_o(nextLcState), .nextLcCnt_o(nextLcCnt),
    .transCntOflwError_o(transCntOflwErr), .transInvalidError_o(transInvalidErr)
  );

  lcCtrlStateStore u_store (
    .clk_i, .arstN_i,
    .progCnt_i(progCnt), .progState_i(progState),
    .nextLcState_i(nextLcState), .nextLcCnt_i(nextLcCnt),
    .lcState_o(lcState), .lcCnt_o(lcCnt), .decLcState_o(decLcState)
  );

endmodule

/* bench/lcCtrlTb.sv */
// ----------------------------------------------------------
// Testbench for the life cycle controller top
// Requests and expected results come from the stimulus file
// Run from the project root so the file path resolves
// ----------------------------------------------------------
`include "lcCtrl_config.svh"

module lcCtrlTb;

  localparam int AckLimit  = 8;
  localparam int PollLimit = 20;

  logic        clk;
  logic        arstN;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [4:0]  wbAdr;
  logic [31:0] wbDatI;
  logic [31:0] wbDatO;
  logic        wbAck;

  int          fd;
  int          rc;
  int          fields;
  int          rowNum;
  string       lineText;
  int          tgt, expState, expCnt, expErr, twice;
  logic [31:0] rdData;

  lcCtrlTop u_lcCtrlTop (
    .clk_i(clk), .arstN_i(arstN),
    .wbCyc_i(wbCyc), .wbStb_i(wbStb), .wbWe_i(wbWe), .wbAdr_i(wbAdr),
    .wbDat_i(wbDatI), .wbDat_o(wbDatO), .wbAck_o(wbAck)
  );

  // Period of 20 units
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic haltRun(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      haltRun($sformatf("Fail at time %0t: request %0d, %s read 0x%0h, expected 0x%0h",
                        $time, rowNum, what, got, exp));
    end
  endtask

  // One Wishbone classic access driven 2 units after the edge and
  // sampled at the same point where the registered ack has settled
  task automatic wbAccess(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    // The acknowledge of the previous access lasts a single cycle
    assert (!wbAck) else begin
      haltRun($sformatf("Fail at time %0t: wbAck still high before a new access", $time));
    end
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatI = wdata;
    do begin
      @(posedge clk);
      #2;
      cycles++;
      if (!wbAck && cycles >= AckLimit) begin
        haltRun("Timeout: the DUT never acknowledged a Wishbone access");
      end
    end while (!wbAck);
    // Every access is answered exactly one cycle after the request
    assert (cycles == 1) else begin
      haltRun($sformatf("Fail at time %0t: wbAck came after %0d cycles, expected 1",
                        $time, cycles));
    end
    rdata = wbDatO;
    // Dropping the strobe here keeps the next edge from starting a new request
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  // Done stays low from the accepted command until PostTransSt
  task automatic waitDone(output logic [31:0] status);
    int polls;
    polls  = 0;
    status = 32'h0;
    while (!status[1]) begin
      if (polls >= PollLimit) begin
        haltRun("Timeout: STATUS never reported the request as done");
      end
      wbAccess(1'b0, `LC_ADDR_STATUS, 32'h0, status);
      polls++;
    end
  endtask

  task automatic runRequest();
    logic [31:0] rd;
    logic [31:0] expStatus;
    wbAccess(1'b1, `LC_ADDR_TARGET, 32'(tgt), rd);
    wbAccess(1'b1, `LC_ADDR_CMD, 32'h1, rd);
    // A second command lands while the FSM is busy and must be dropped
    if (twice != 0) begin
      wbAccess(1'b1, `LC_ADDR_CMD, 32'h1, rd);
    end
    waitDone(rd);
    // Status layout is busy, done, overflow, invalid from bit 0 up
    expStatus = {28'h0, (expErr == 2), (expErr == 1), 1'b1, 1'b0};
    checkValue("STATUS", rd, expStatus);
    wbAccess(1'b0, `LC_ADDR_STATE, 32'h0, rd);
    checkValue("STATE", rd, 32'(expState));
    wbAccess(1'b0, `LC_ADDR_CNT, 32'h0, rd);
    checkValue("CNT", rd, 32'(expCnt));
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    arstN  = 1'b0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = 5'h0;
    wbDatI = 32'h0;
    rowNum = 0;
    repeat (4) @(posedge clk);
    #2;
    arstN = 1'b1;

    // A blank store reads as Raw with a zero count and idle status
    wbAccess(1'b0, `LC_ADDR_STATUS, 32'h0, rdData);
    checkValue("STATUS after reset", rdData, 32'h0);
    wbAccess(1'b0, `LC_ADDR_STATE, 32'h0, rdData);
    checkValue("STATE after reset", rdData, 32'h0);
    wbAccess(1'b0, `LC_ADDR_CNT, 32'h0, rdData);
    checkValue("CNT after reset", rdData, 32'h0);

    fd = $fopen("bench/lcCtrlStimulus.txt", "r");
    if (fd == 0) begin
      haltRun("Could not open the stimulus file bench/lcCtrlStimulus.txt");
    end
    while (!$feof(fd)) begin
      lineText = "";
      rc = $fgets(lineText, fd);
      // Comment lines and blank lines carry no request
      if (rc > 0 && lineText.len() > 1 && lineText[0] != "#") begin
        fields = $sscanf(lineText, "%d %d %d %d %d", tgt, expState, expCnt, expErr, twice);
        if (fields != 5) begin
          haltRun($sformatf("Malformed line in the stimulus file: %s", lineText));
        end
        rowNum++;
        runRequest();
      end
    end
    $fclose(fd);

    if (rowNum == 0) begin
      haltRun("The stimulus file held no requests");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* lcCtrl.f */
+incdir+include
logic/lcCtrlPkg.sv
logic/lcCtrlRegs.sv
logic/lcCtrlFsm.sv
logic/lcCtrlStateTransition.sv
logic/lcCtrlStateStore.sv
logic/lcCtrlTop.sv
bench/lcCtrlTb.sv

/* Bender.yml */
package:
  name: lcCtrl

export_include_dirs:
  - include

sources:
  - logic/lcCtrlPkg.sv
  - logic/lcCtrlRegs.sv
  - logic/lcCtrlFsm.sv
  - logic/lcCtrlStateTransition.sv
  - logic/lcCtrlStateStore.sv
  - logic/lcCtrlTop.sv
  - target: test
    files:
      - bench/lcCtrlTb.sv

/* bench/lcCtrlStimulus.txt */
# Columns: target index, expected state index, expected counter, expected error
# (0 none, 1 overflow, 2 invalid), second CMD write while busy (0 or 1)
1 1 1 0 0
5 5 2 0 0
3 3 3 0 0
8 8 4 0 1
9 9 5 0 0
8 9 6 2 0
0 9 7 2 0
1 9 8 2 0
6 9 9 2 0
9 9 10 2 0
13 9 11 2 0
15 9 12 2 0
4 9 13 2 0
2 9 14 2 0
5 9 15 2 0
7 9 16 2 0
3 9 17 2 0
8 9 18 2 0
0 9 19 2 0
1 9 20 2 0
6 9 21 2 0
9 9 22 2 0
13 9 23 2 0
8 9 24 2 0
8 9 24 1 0
12 12 24 0 0
12 12 24 2 0
11 12 24 1 0
